/* src/pitch_pkg.sv */
package pitch_pkg;

    // Widths of the SDRAM side
    localparam int ADDR_W  = 23;
    localparam int DATA_W  = 32;
    localparam int COUNT_W = 23;

    // Speed ratio in eighths where 8 is unity
    localparam int SPEED_W   = 4;
    localparam int FRAC_BITS = 3;

    // Source position is a word offset plus the fraction
    localparam int POS_W = ADDR_W + FRAC_BITS;

    // Sample count sits in the low bits of the header word
    localparam int HEADER_LEN_BITS = 23;

    typedef logic [ADDR_W-1:0]  sdram_addr_t;
    typedef logic [DATA_W-1:0]  sample_word_t;   // Left in upper half, right in lower
    typedef logic [COUNT_W-1:0] sample_count_t;
    typedef logic [SPEED_W-1:0] speed_t;
    typedef logic [POS_W-1:0]   src_pos_t;

    // Controller sequence
    typedef enum logic [2:0] {
        IDLE,
        READ_HEADER,
        WRITE_HEADER,
        READ_SAMPLE,
        WRITE_SAMPLE,
        FINISH
    } ctrl_state_t;

endpackage

/* src/mem_cmd_if.sv */
`timescale 1ns/1ps

// One command in flight at a time, next one only after ack
interface mem_cmd_if;

    logic                    rd_req;   // Single-cycle strobes
    logic                    wr_req;
    pitch_pkg::sdram_addr_t  addr;
    pitch_pkg::sample_word_t wdata;

    logic                    ack;      // Access ended
    pitch_pkg::sample_word_t rdata;    // Held until the next read

    modport ctrl (
        output rd_req,
        output wr_req,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport access (
        input  rd_req,
        input  wr_req,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

/* src/sdram_access.sv */
`timescale 1ns/1ps

// Turns command strobes into read/write levels held until finished
module sdram_access (
    input  logic                    i_clk,
    input  logic                    i_rst,
    mem_cmd_if.access               cmd,
    output logic                    read,
    output logic                    write,
    output pitch_pkg::sdram_addr_t  addr,
    output pitch_pkg::sample_word_t writedata,
    input  pitch_pkg::sample_word_t readdata,
    input  logic                    sdram_finished
);

    logic                    busy;
    logic                    ack_q;
    pitch_pkg::sample_word_t rdata_q;

    assign busy = read || write;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            read  <= 1'b0;
            write <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (busy) begin
                if (sdram_finished) begin
                    read  <= 1'b0;
                    write <= 1'b0;
                    ack_q <= 1'b1;
                end
            end else if (cmd.rd_req) begin
                read <= 1'b1;
            end else if (cmd.wr_req) begin
                write <= 1'b1;
            end
        end
    end

    // Address and data stay put for the whole access
    always_ff @(posedge i_clk) begin
        if (!busy && (cmd.rd_req || cmd.wr_req)) begin
            addr <= cmd.addr;
        end
        if (!busy && cmd.wr_req) begin
            writedata <= cmd.wdata;
        end
        if (read && sdram_finished) begin
            rdata_q <= readdata;   // Valid only in the finished cycle
        end
    end

    assign cmd.ack   = ack_q;
    assign cmd.rdata = rdata_q;

endmodule

/* src/resample_addr_gen.sv */
`timescale 1ns/1ps

// Fractional source walk, one step per output sample
module resample_addr_gen (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     init,
    input  logic                     step,
    input  pitch_pkg::sdram_addr_t   src_base,
    input  pitch_pkg::sample_count_t sample_count,
    input  pitch_pkg::speed_t        speed,
    output pitch_pkg::sdram_addr_t   src_addr,
    output logic                     last
);

    localparam int POS_MSB = $bits(pitch_pkg::src_pos_t) - 1;

    pitch_pkg::src_pos_t      pos;       // Word offset with FRAC_BITS fraction
    pitch_pkg::sdram_addr_t   base_q;
    pitch_pkg::sample_count_t count_q;
    pitch_pkg::sample_count_t index;     // Output sample number
    pitch_pkg::sdram_addr_t   pos_int;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            pos     <= '0;
            base_q  <= '0;
            count_q <= '0;
            index   <= '0;
        end else if (init) begin
            pos     <= '0;
            base_q  <= src_base;
            count_q <= sample_count;
            index   <= '0;
        end else if (step) begin
            pos   <= pos + pitch_pkg::src_pos_t'(speed);
            index <= index + pitch_pkg::sample_count_t'(1);
        end
    end

    // Drop the fraction
    assign pos_int = pos[POS_MSB:pitch_pkg::FRAC_BITS];

    // Skip the header word
    assign src_addr = base_q + pitch_pkg::sdram_addr_t'(1) + pos_int;

    assign last = (index == count_q - pitch_pkg::sample_count_t'(1));

endmodule

/* src/resample_ctrl.sv */
`timescale 1ns/1ps

// Header copy, then read/write pairs until the last sample
module resample_ctrl (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     start,
    input  pitch_pkg::sdram_addr_t   src_base,
    input  pitch_pkg::sdram_addr_t   dst_base,
    mem_cmd_if.ctrl                  mem,
    output logic                     gen_init,
    output logic                     gen_step,
    input  pitch_pkg::sdram_addr_t   src_addr,
    input  logic                     last,
    output pitch_pkg::sample_count_t sample_count,
    output logic                     done
);

    pitch_pkg::ctrl_state_t   state;
    pitch_pkg::sdram_addr_t   hdr_addr;
    pitch_pkg::sdram_addr_t   dst_ptr;   // Next destination word
    pitch_pkg::sample_count_t count_q;
    logic                     issue;     // First cycle of an access state

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state    <= pitch_pkg::IDLE;
            issue    <= 1'b0;
            hdr_addr <= '0;
            dst_ptr  <= '0;
            count_q  <= '0;
        end else begin
            issue <= 1'b0;
            case (state)
                pitch_pkg::IDLE: begin
                    if (start) begin
                        hdr_addr <= src_base;
                        dst_ptr  <= dst_base;
                        state    <= pitch_pkg::READ_HEADER;
                        issue    <= 1'b1;
                    end
                end
                pitch_pkg::READ_HEADER: begin
                    if (mem.ack) begin
                        count_q <= mem.rdata[pitch_pkg::HEADER_LEN_BITS-1:0];
                        state   <= pitch_pkg::WRITE_HEADER;
                        issue   <= 1'b1;
                    end
                end
                pitch_pkg::WRITE_HEADER: begin
                    if (mem.ack) begin
                        dst_ptr <= dst_ptr + pitch_pkg::sdram_addr_t'(1);
                        if (count_q == '0) begin
                            state <= pitch_pkg::FINISH;
                        end else begin
                            state <= pitch_pkg::READ_SAMPLE;
                            issue <= 1'b1;
                        end
                    end
                end
                pitch_pkg::READ_SAMPLE: begin
                    if (mem.ack) begin
                        state <= pitch_pkg::WRITE_SAMPLE;
                        issue <= 1'b1;
                    end
                end
                pitch_pkg::WRITE_SAMPLE: begin
                    if (mem.ack) begin
                        dst_ptr <= dst_ptr + pitch_pkg::sdram_addr_t'(1);
                        if (last) begin
                            state <= pitch_pkg::FINISH;
                        end else begin
                            state <= pitch_pkg::READ_SAMPLE;
                            issue <= 1'b1;
                        end
                    end
                end
                pitch_pkg::FINISH: state <= pitch_pkg::IDLE;
                default:           state <= pitch_pkg::IDLE;
            endcase
        end
    end

    assign mem.rd_req = issue && (state == pitch_pkg::READ_HEADER ||
                                  state == pitch_pkg::READ_SAMPLE);
    assign mem.wr_req = issue && (state == pitch_pkg::WRITE_HEADER ||
                                  state == pitch_pkg::WRITE_SAMPLE);

    assign mem.addr = (state == pitch_pkg::READ_HEADER) ? hdr_addr :
                      (state == pitch_pkg::READ_SAMPLE) ? src_addr : dst_ptr;

    // Sample write reuses the word still held from the read
    assign mem.wdata = (state == pitch_pkg::WRITE_HEADER) ?
                       pitch_pkg::sample_word_t'(count_q) : mem.rdata;

    // Generator moves on the ack, so src_addr is ready for the next read
    assign gen_init = (state == pitch_pkg::WRITE_HEADER) && mem.ack && (count_q != '0);
    assign gen_step = (state == pitch_pkg::WRITE_SAMPLE) && mem.ack && !last;

    assign sample_count = count_q;
    assign done         = (state == pitch_pkg::FINISH);

endmodule

/* src/pitch_core.sv */
`timescale 1ns/1ps

module pitch_core (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    pitch_start,
    input  pitch_pkg::sdram_addr_t  src_base,
    input  pitch_pkg::sdram_addr_t  dst_base,
    input  pitch_pkg::speed_t       pitch_speed,   // Held stable for a run
    output logic                    pitch_done,
    output logic                    pitch_read,
    output logic                    pitch_write,
    output pitch_pkg::sdram_addr_t  pitch_addr,
    input  pitch_pkg::sample_word_t pitch_readdata,
    output pitch_pkg::sample_word_t pitch_writedata,
    input  logic                    pitch_sdram_finished
);

    mem_cmd_if mem_if ();

    logic                     gen_init;
    logic                     gen_step;
    logic                     last;
    pitch_pkg::sdram_addr_t   src_addr;
    pitch_pkg::sample_count_t sample_count;

    resample_ctrl ctrl_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .start        (pitch_start),
        .src_base     (src_base),
        .dst_base     (dst_base),
        .mem          (mem_if.ctrl),
        .gen_init     (gen_init),
        .gen_step     (gen_step),
        .src_addr     (src_addr),
        .last         (last),
        .sample_count (sample_count),
        .done         (pitch_done)
    );

    resample_addr_gen gen_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .init         (gen_init),
        .step         (gen_step),
        .src_base     (src_base),
        .sample_count (sample_count),
        .speed        (pitch_speed),
        .src_addr     (src_addr),
        .last         (last)
    );

    sdram_access access_i (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .cmd            (mem_if.access),
        .read           (pitch_read),
        .write          (pitch_write),
        .addr           (pitch_addr),
        .writedata      (pitch_writedata),
        .readdata       (pitch_readdata),
        .sdram_finished (pitch_sdram_finished)
    );

endmodule

/* sim/pitch_core_asserts.sv */
`timescale 1ns/1ps

// SDRAM side and done protocol checks
module pitch_core_asserts (
    input logic                    i_clk,
    input logic                    i_rst,
    input logic                    pitch_read,
    input logic                    pitch_write,
    input logic                    pitch_done,
    input pitch_pkg::sdram_addr_t  pitch_addr,
    input pitch_pkg::sample_word_t pitch_writedata,
    input pitch_pkg::ctrl_state_t  state
);

    int fail_count = 0;   // Failed properties so far

    a_no_read_write: assert property (@(posedge i_clk) disable iff (i_rst)
        !(pitch_read && pitch_write))
        else begin
            $error("read and write high together");
            fail_count++;
        end

    // Address and data must not move during a held write
    a_write_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (pitch_write && $past(pitch_write)) |-> ($stable(pitch_addr) && $stable(pitch_writedata)))
        else begin
            $error("write address or data changed during the access");
            fail_count++;
        end

    a_done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        pitch_done |=> !pitch_done)
        else begin
            $error("done held for more than one cycle");
            fail_count++;
        end

    a_read_state: assert property (@(posedge i_clk) disable iff (i_rst)
        pitch_read |-> (state inside {pitch_pkg::READ_HEADER, pitch_pkg::READ_SAMPLE}))
        else begin
            $error("read level outside a read state");
            fail_count++;
        end

    a_reset_quiet: assert property (@(posedge i_clk)
        i_rst |=> (!pitch_read && !pitch_write && !pitch_done))
        else begin
            $error("read, write or done active during reset");
            fail_count++;
        end

endmodule

bind pitch_core pitch_core_asserts asserts_i (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .pitch_read      (pitch_read),
    .pitch_write     (pitch_write),
    .pitch_done      (pitch_done),
    .pitch_addr      (pitch_addr),
    .pitch_writedata (pitch_writedata),
    .state           (ctrl_i.state)
);

/* sim/pitch_core_tb.sv */
`timescale 1ns/1ps

module pitch_core_tb;

    localparam int TOTAL_N   = 100;   // Sum of N over every run below
    localparam int NUM_TESTS = 6;
    localparam int MAX_CYCLES = 20 * (TOTAL_N + NUM_TESTS) * 8;

    logic                    i_clk;
    logic                    i_rst;
    logic                    pitch_start;
    pitch_pkg::sdram_addr_t  src_base;
    pitch_pkg::sdram_addr_t  dst_base;
    pitch_pkg::speed_t       pitch_speed;
    logic                    pitch_done;
    logic                    pitch_read;
    logic                    pitch_write;
    pitch_pkg::sdram_addr_t  pitch_addr;
    pitch_pkg::sample_word_t pitch_readdata;
    pitch_pkg::sample_word_t pitch_writedata;
    logic                    pitch_sdram_finished;

    pitch_pkg::sample_word_t mem [pitch_pkg::sdram_addr_t];   // Sparse SDRAM
    logic [31:0]             seed = 32'hd534_4ac9;
    logic                    mem_busy;
    logic [1:0]              wait_left;
    int                      wr_count;
    pitch_pkg::sdram_addr_t  wr_min;
    pitch_pkg::sdram_addr_t  wr_max;
    int                      errors = 0;
    int                      tests_run = 0;
    int                      tests_failed = 0;
    int                      cycles = 0;

    pitch_core dut_i (.*);

    always #5 i_clk = ~i_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Every address bit shows up in the word
    function automatic pitch_pkg::sample_word_t fill_word(input pitch_pkg::sdram_addr_t a);
        return {a[15:0] ^ 16'h3c5a, a[22:16] ^ 7'h11, a[8:0]};
    endfunction

    // Finished comes 1 to 4 cycles after the level is seen
    always @(posedge i_clk) begin
        if (i_rst) begin
            mem_busy             <= 1'b0;
            pitch_sdram_finished <= 1'b0;
        end else begin
            pitch_sdram_finished <= 1'b0;
            if (pitch_sdram_finished) begin
                mem_busy <= 1'b0;
            end else if (mem_busy) begin
                if (wait_left == 2'd0) begin
                    pitch_sdram_finished <= 1'b1;
                    if (pitch_write) begin
                        mem[pitch_addr] = pitch_writedata;
                        wr_count++;
                        if (pitch_addr < wr_min) wr_min = pitch_addr;
                        if (pitch_addr > wr_max) wr_max = pitch_addr;
                    end else if (mem.exists(pitch_addr)) begin
                        pitch_readdata <= mem[pitch_addr];
                    end else begin
                        $display("Read from unloaded address %h at %0t ns", pitch_addr, $time);
                        errors++;
                    end
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end else if (pitch_read || pitch_write) begin
                seed = lcg_next(seed);
                mem_busy  <= 1'b1;
                wait_left <= seed[17:16];
            end
        end
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the core never finished", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_word(input string name, input pitch_pkg::sample_word_t exp,
                              input pitch_pkg::sample_word_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input pitch_pkg::sdram_addr_t exp,
                              input pitch_pkg::sdram_addr_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input pitch_pkg::sample_count_t exp,
                               input pitch_pkg::sample_count_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_output(input string name, input pitch_pkg::sdram_addr_t a,
                                input pitch_pkg::sample_word_t exp);
        if (!mem.exists(a)) begin
            $display("%s at address %h was never written", name, a);
            errors++;
        end else begin
            check_word(name, exp, mem[a]);
        end
    endtask

    // Entered right after a rising edge, returns right after one
    task automatic run_resample(input pitch_pkg::sdram_addr_t src,
                                input pitch_pkg::sdram_addr_t dst,
                                input pitch_pkg::sample_word_t header,
                                input pitch_pkg::speed_t speed,
                                input bit extra_start, input int quiet_cycles);
        pitch_pkg::sample_count_t n;
        int idx;
        int extra_done;
        int busy_seen;
        n = header[pitch_pkg::HEADER_LEN_BITS-1:0];
        mem.delete();
        mem[src] = header;
        for (int i = 0; i <= 2 * n; i++) begin
            mem[src + 1 + i] = fill_word(src + 1 + i);
        end
        wr_count = 0;
        wr_min = '1;
        wr_max = '0;
        src_base    <= src;
        dst_base    <= dst;
        pitch_speed <= speed;
        pitch_start <= 1'b1;
        @(posedge i_clk);
        pitch_start <= 1'b0;
        if (extra_start) begin
            repeat (6) @(posedge i_clk);
            pitch_start <= 1'b1;   // Core is mid-run here
            @(posedge i_clk);
            pitch_start <= 1'b0;
        end
        do @(negedge i_clk); while (!pitch_done);
        check_output("dst header", dst, pitch_pkg::sample_word_t'(n));
        for (int k = 0; k < n; k++) begin
            idx = (k * int'(speed)) / 8;
            check_output($sformatf("out[%0d]", k), dst + 1 + k, fill_word(src + 1 + idx));
        end
        check_count("write count", n + 1, pitch_pkg::sample_count_t'(wr_count));
        check_addr("lowest write address", dst, wr_min);
        check_addr("highest write address", dst + n, wr_max);
        @(posedge i_clk);
        extra_done = 0;
        busy_seen = 0;
        repeat (quiet_cycles) begin
            @(negedge i_clk);
            if (pitch_done) extra_done++;
            if (pitch_read || pitch_write) busy_seen++;
        end
        if (quiet_cycles > 0) begin
            @(posedge i_clk);
            check_count("done pulses after the run", 0, pitch_pkg::sample_count_t'(extra_done));
            if (busy_seen != 0) begin
                $display("Memory still accessed %0d cycles after done", busy_seen);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic identity_copy();
        int e0 = errors;
        run_resample(23'h00_1000, 23'h00_2000, 32'd16, 4'd8, 1'b0, 0);
        report_test("identity copy", e0);
    endtask

    task automatic decimate_copy();
        int e0 = errors;
        run_resample(23'h00_3000, 23'h00_4000, 32'd20, 4'd12, 1'b0, 0);
        report_test("decimation", e0);
    endtask

    task automatic repeat_copy();
        int e0 = errors;
        run_resample(23'h00_5000, 23'h00_6000, 32'd12, 4'd4, 1'b0, 0);
        run_resample(23'h00_5100, 23'h00_6100, 32'd5, 4'd0, 1'b0, 0);
        report_test("repetition", e0);
    endtask

    task automatic zero_length_run();
        int e0 = errors;
        run_resample(23'h00_7000, 23'h00_7100, 32'd0, 4'd8, 1'b0, 0);
        report_test("zero length", e0);
    endtask

    task automatic busy_start_ignored();
        int e0 = errors;
        run_resample(23'h01_0000, 23'h02_0000, 32'd24, 4'd10, 1'b1, 30);
        report_test("latency and busy start", e0);
    endtask

    task automatic masked_back_to_back();
        int e0 = errors;
        run_resample(23'h7f_0000, 23'h7f_8000, {9'h1a5, 23'd9}, 4'd6, 1'b0, 0);
        run_resample(23'h40_0000, 23'h41_0000, {9'h0ff, 23'd14}, 4'd13, 1'b0, 0);
        report_test("header mask and back to back", e0);
    endtask

    initial begin
        i_clk                = 1'b0;
        i_rst                = 1'b1;
        pitch_start          = 1'b0;
        src_base             = '0;
        dst_base             = '0;
        pitch_speed          = 4'd8;
        pitch_readdata       = '0;
        pitch_sdram_finished = 1'b0;
        repeat (4) @(posedge i_clk);
        i_rst <= 1'b0;
        repeat (2) @(posedge i_clk);
        identity_copy();
        decimate_copy();
        repeat_copy();
        zero_length_run();
        busy_start_ignored();
        masked_back_to_back();
        if (dut_i.asserts_i.fail_count != 0) begin
            $display("Protocol assertions failed %0d times", dut_i.asserts_i.fail_count);
            errors += dut_i.asserts_i.fail_count;
        end
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/pitch_pkg.sv
src/mem_cmd_if.sv
src/sdram_access.sv
src/resample_addr_gen.sv
src/resample_ctrl.sv
src/pitch_core.sv
sim/pitch_core_asserts.sv
sim/pitch_core_tb.sv
